// File: ahb/ahb_req_decode.sv
//**************************************************************************
// Pure combinational check of the registered AHB request
// Anything outside the DCCM window is rejected; DCCM writes need word or
// doubleword size; every access must be aligned to its size
//**************************************************************************
`timescale 1ns/1ps

module ahb_req_decode (
   input  bridge_pkg::ahb_req_t               req,
   output logic                               req_err,
   output logic [bridge_pkg::strb_w-1:0]      wstrb
);

   logic in_dccm;                                  // Address hits the DCCM window
   logic size_err;                                 // DCCM write narrower than a word
   logic align_err;                                // Address not a multiple of the size

   // Window is inclusive of the last byte
   assign in_dccm = (req.haddr >= bridge_pkg::dccm_base) &&
                    (req.haddr <= bridge_pkg::dccm_base + bridge_pkg::dccm_size - 32'd1);

   assign size_err = in_dccm & req.hwrite &
                     ~((req.hsize == bridge_pkg::hsize_word) |
                       (req.hsize == bridge_pkg::hsize_dword));

   always_comb begin
      case (req.hsize)
         bridge_pkg::hsize_half:  align_err = req.haddr[0];
         bridge_pkg::hsize_word:  align_err = |req.haddr[1:0];
         bridge_pkg::hsize_dword: align_err = |req.haddr[2:0];
         default:                 align_err = 1'b0;   // Bytes are always aligned
      endcase
   end

   assign req_err = ~in_dccm | size_err | align_err;

   //***********************************************************************
   // Write strobes as a lane run shifted by the low address bits
   //***********************************************************************
   always_comb begin
      case (req.hsize)
         bridge_pkg::hsize_byte: wstrb = 8'b0000_0001 << req.haddr[2:0];
         bridge_pkg::hsize_half: wstrb = 8'b0000_0011 << req.haddr[2:0];
         bridge_pkg::hsize_word: wstrb = 8'b0000_1111 << req.haddr[2:0];
         default:                wstrb = 8'b1111_1111;   // Doubleword fills the lane
      endcase
   end

endmodule

// File: ahb/ahb_slave_ctrl.sv
//**************************************************************************
// AHB-Lite slave side of the bridge, one transfer in flight at a time
// Reads block the bus until rvalid; rready is assumed always high downstream
// Errors follow the two-cycle AHB response
//**************************************************************************
`timescale 1ns/1ps

module ahb_slave_ctrl (
   input  logic                               ahb_clk,
   input  logic                               rst,
   input  logic [bridge_pkg::addr_w-1:0]      haddr,
   input  logic [2:0]                         hsize,
   input  logic [1:0]                         htrans,
   input  logic                               hwrite,
   input  logic                               hsel,
   input  logic                               hreadyin,
   output logic                               hreadyout,
   output logic                               hresp,
   output logic [bridge_pkg::data_w-1:0]      hrdata,
   output bridge_pkg::ahb_req_t               req,
   input  logic                               req_err,
   output logic                               cmd_load,
   input  logic                               cmd_full,
   input  logic                               rvalid,
   input  bridge_pkg::axi_r_t                 r
);

   bridge_pkg::buf_state_t state, state_nxt;
   logic                   state_en;

   logic       hready;                             // Bus-wide ready seen by this slave
   logic       accept;                             // Address phase taken this edge
   logic [1:0] htrans_q;                           // Transfer type of the last edge
   logic       hresp_q;
   logic       hready_q;
   logic       pending;                            // Registered request still owned
   logic       rdata_en;
   logic       read_err, read_err_in;

   assign hready = hreadyout & hreadyin;
   assign accept = hready & hsel & (htrans == bridge_pkg::htrans_nonseq);

   //***********************************************************************
   // Slave FSM
   //***********************************************************************
   always_comb begin
      state_nxt   = bridge_pkg::idle;
      state_en    = 1'b0;
      cmd_load    = 1'b0;
      rdata_en    = 1'b0;
      read_err_in = 1'b0;
      case (state)
         bridge_pkg::idle: begin
            state_nxt = hwrite ? bridge_pkg::wr : bridge_pkg::rd;
            state_en  = accept;
         end
         bridge_pkg::wr: begin
            // Data phase overlaps the next address phase
            if (hresp | ~accept) begin
               state_nxt = bridge_pkg::idle;
            end else begin
               state_nxt = hwrite ? bridge_pkg::wr : bridge_pkg::rd;
            end
            state_en = ~cmd_full | hresp;          // Hold while the buffer is busy
            cmd_load = ~cmd_full & ~hresp;         // Rejected writes never reach AXI
         end
         bridge_pkg::rd: begin
            state_nxt = hresp ? bridge_pkg::idle : bridge_pkg::pend;
            state_en  = ~cmd_full | hresp;
            cmd_load  = ~cmd_full & ~hresp;
         end
         bridge_pkg::pend: begin
            state_nxt   = bridge_pkg::idle;        // Data shown next cycle
            state_en    = rvalid;
            rdata_en    = rvalid;
            read_err_in = rvalid & (r.resp != bridge_pkg::axi_resp_okay);
         end
         default: begin
            state_nxt = bridge_pkg::idle;
            state_en  = 1'b1;
         end
      endcase
   end

   //***********************************************************************
   // AHB response
   //***********************************************************************
   assign pending = (htrans_q != bridge_pkg::htrans_idle) & (state != bridge_pkg::idle);

   // First error cycle from decode or read response, second from the flops
   assign hresp = (pending & req_err) | read_err | (hresp_q & ~hready_q);

   always_comb begin
      if (hresp) begin
         hreadyout = hresp_q & ~hready_q;          // Low first, high second
      end else begin
         hreadyout = (~cmd_full | (state == bridge_pkg::idle)) &
                     (state != bridge_pkg::rd) & (state != bridge_pkg::pend);
      end
   end

   //***********************************************************************
   // Registers
   //***********************************************************************
   always_ff @(posedge ahb_clk) begin
      if (rst) begin
         state    <= bridge_pkg::idle;
         htrans_q <= bridge_pkg::htrans_idle;
         hresp_q  <= 1'b0;
         hready_q <= 1'b1;                         // Bus comes out of reset ready
         read_err <= 1'b0;
      end else begin
         if (state_en) begin
            state <= state_nxt;
         end
         htrans_q <= hsel ? htrans : bridge_pkg::htrans_idle;
         hresp_q  <= hresp;
         hready_q <= hready;
         read_err <= read_err_in;                  // Single-cycle pulse
      end
   end

   // Address phase capture
   always_ff @(posedge ahb_clk) begin
      if (accept) begin
         req.haddr  <= haddr;
         req.hsize  <= hsize;
         req.hwrite <= hwrite;
      end
   end

   // Read data holds until the next read returns
   always_ff @(posedge ahb_clk) begin
      if (rdata_en) begin
         hrdata <= r.data;
      end
   end

endmodule

// File: axi/axi_cmd_buf.sv
//**************************************************************************
// One-entry AXI command buffer, fed from the AHB data phase
// wvalid moves with awvalid; the slave must raise wready with awready
// Single beat only, no write response is tracked
//**************************************************************************
`timescale 1ns/1ps

module axi_cmd_buf (
   input  logic                               ahb_clk,
   input  logic                               rst,
   input  logic                               cmd_load,
   input  bridge_pkg::ahb_req_t               req,
   input  logic [bridge_pkg::strb_w-1:0]      wstrb,
   input  logic [bridge_pkg::data_w-1:0]      hwdata,
   output logic                               cmd_full,
   output logic                               awvalid,
   input  logic                               awready,
   output bridge_pkg::axi_addr_t              aw,
   output logic                               wvalid,
   output bridge_pkg::axi_w_t                 w,
   output logic                               arvalid,
   input  logic                               arready,
   output bridge_pkg::axi_addr_t              ar
);

   logic                  cmd_vld;                 // Entry occupied
   logic                  cmd_write;               // Steers to AW/W or AR
   bridge_pkg::axi_addr_t cmd_a;
   bridge_pkg::axi_w_t    cmd_w;
   logic                  aw_hs, ar_hs;            // Handshakes this edge
   logic                  cmd_done;

   assign aw_hs    = awvalid & awready;
   assign ar_hs    = arvalid & arready;
   assign cmd_done = aw_hs | ar_hs;

   // Full only while the held command is still waiting
   assign cmd_full = cmd_vld & ~cmd_done;

   //***********************************************************************
   // Entry valid
   //***********************************************************************
   always_ff @(posedge ahb_clk) begin
      if (rst) begin
         cmd_vld <= 1'b0;
      end else if (cmd_load) begin
         cmd_vld <= 1'b1;                          // New command wins over a drain
      end else if (cmd_done) begin
         cmd_vld <= 1'b0;
      end
   end

   // Command payload
   always_ff @(posedge ahb_clk) begin
      if (cmd_load) begin
         cmd_write  <= req.hwrite;
         cmd_a.addr <= req.haddr;
         cmd_a.size <= req.hsize;
         cmd_w.strb <= wstrb;
         cmd_w.data <= hwdata;                     // Valid in the write data phase
      end
   end

   //***********************************************************************
   // Channel steering
   //***********************************************************************
   assign awvalid = cmd_vld & cmd_write;
   assign wvalid  = cmd_vld & cmd_write;           // Same beat as AW
   assign arvalid = cmd_vld & ~cmd_write;

   assign aw = cmd_a;
   assign ar = cmd_a;
   assign w  = cmd_w;

endmodule

// File: common/bridge_pkg.sv
//**************************************************************************
// Shared widths, DCCM window, AHB and AXI codes for the AHB to AXI bridge
// Single-beat transfers only; one 64-bit AXI data lane
//**************************************************************************
package bridge_pkg;

   // Bus widths
   localparam int addr_w = 32;
   localparam int data_w = 64;
   localparam int strb_w = data_w / 8;             // One strobe per byte lane

   // DCCM window, the only legal target
   localparam logic [addr_w-1:0] dccm_base = 32'hF004_0000;
   localparam logic [addr_w-1:0] dccm_size = 32'h0001_0000;   // 64 KB

   // AHB transfer types
   localparam logic [1:0] htrans_idle   = 2'b00;
   localparam logic [1:0] htrans_busy   = 2'b01;
   localparam logic [1:0] htrans_nonseq = 2'b10;

   // AHB and AXI size codes share one encoding
   localparam logic [2:0] hsize_byte  = 3'd0;
   localparam logic [2:0] hsize_half  = 3'd1;
   localparam logic [2:0] hsize_word  = 3'd2;
   localparam logic [2:0] hsize_dword = 3'd3;

   localparam logic [1:0] axi_resp_okay = 2'b00;

   // Slave FSM states
   typedef enum logic [1:0] {
      idle = 2'b00,                                // Nothing accepted
      wr   = 2'b01,                                // Write data phase
      rd   = 2'b10,                                // Read waiting for the buffer
      pend = 2'b11                                 // Read issued, waiting on rvalid
   } buf_state_t;

   //***********************************************************************
   // Channel payloads
   //***********************************************************************
   typedef struct packed {
      logic [addr_w-1:0] haddr;
      logic [2:0]        hsize;
      logic              hwrite;
   } ahb_req_t;                                    // 36 bits

   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [2:0]        size;
   } axi_addr_t;                                   // Shared by AW and AR

   typedef struct packed {
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
   } axi_w_t;

   typedef struct packed {
      logic [data_w-1:0] data;
      logic [1:0]        resp;
   } axi_r_t;

endpackage

// File: list.f
common/bridge_pkg.sv
ahb/ahb_req_decode.sv
ahb/ahb_slave_ctrl.sv
axi/axi_cmd_buf.sv
verilog/ahb_to_axi_bridge.sv
test/bridge_chk.sv
test/tb_ahb_to_axi.sv

// File: test/bridge_chk.sv
//**************************************************************************
// Protocol checker bound into the bridge top level
// Clocked on ahb_clk, idle while rst is high
//**************************************************************************
`timescale 1ns/1ps

module bridge_chk (
   input logic                  ahb_clk,
   input logic                  rst,
   input logic                  hreadyout,
   input logic                  hresp,
   input logic                  awvalid,
   input logic                  awready,
   input bridge_pkg::axi_addr_t aw,
   input logic                  wvalid,
   input bridge_pkg::axi_w_t    w,
   input logic                  arvalid,
   input logic                  arready,
   input bridge_pkg::axi_addr_t ar
);

   int unsigned fail_cnt = 0;                      // Failed assertion count

   // Second error cycle must follow the first one
   assert property (@(posedge ahb_clk) disable iff (rst)
                    (hresp && hreadyout) |-> $past(hresp && !hreadyout))
   else begin
      fail_cnt++;
      $error("hresp with hreadyout high without a first error cycle");
   end

   // AW and W hold until taken
   assert property (@(posedge ahb_clk) disable iff (rst)
                    (awvalid && !awready) |=> (awvalid && $stable(aw) && $stable(w)))
   else begin
      fail_cnt++;
      $error("awvalid or its payload changed before awready");
   end

   assert property (@(posedge ahb_clk) disable iff (rst)
                    (arvalid && !arready) |=> (arvalid && $stable(ar)))
   else begin
      fail_cnt++;
      $error("arvalid or its payload changed before arready");
   end

   assert property (@(posedge ahb_clk) disable iff (rst) (awvalid == wvalid))
   else begin
      fail_cnt++;
      $error("awvalid and wvalid differ");
   end

endmodule

bind ahb_to_axi_bridge bridge_chk i_bridge_chk (
   .ahb_clk   (ahb_clk),
   .rst       (rst),
   .hreadyout (hreadyout),
   .hresp     (hresp),
   .awvalid   (awvalid),
   .awready   (awready),
   .aw        (aw),
   .wvalid    (wvalid),
   .w         (w),
   .arvalid   (arvalid),
   .arready   (arready),
   .ar        (ar)
);

// File: test/tb_ahb_to_axi.sv
//**************************************************************************
// Testbench for the AHB to AXI bridge, one AHB transfer at a time
// AXI slave model answers after 0 to 5 cycles; one read address errors
//**************************************************************************
`timescale 1ns/1ps

module tb_ahb_to_axi;

   typedef struct packed {
      logic        dec_err;                        // Two-cycle hresp, no AXI beat
      logic        rd_err;                         // AR issued, rresp not OKAY
      logic        write;
      logic [31:0] addr;
      logic [2:0]  size;
      logic [63:0] data;
      logic [7:0]  strb;
   } exp_t;

   logic                  ahb_clk = 1'b0;
   logic                  rst, hwrite, hsel, hreadyin, hreadyout, hresp;
   logic [31:0]           haddr;
   logic [2:0]            hsize;
   logic [1:0]            htrans;
   logic [63:0]           hwdata, hrdata;
   logic                  awvalid, wvalid, arvalid;
   logic                  awready = 1'b0;
   logic                  wready  = 1'b0;
   logic                  arready = 1'b0;
   logic                  rvalid  = 1'b0;
   bridge_pkg::axi_addr_t aw, ar;
   bridge_pkg::axi_w_t    w;
   bridge_pkg::axi_r_t    r = '0;

   exp_t        aw_exp_q[$], ar_exp_q[$];          // Beats still owed, in issue order
   exp_t        aw_e, ar_e, cur_exp;
   logic        dphase;                            // AHB data phase open
   int unsigned errors = 0, checks = 0, err_mark = 0, cycles = 0, chk_fails;
   int unsigned max_cycles = 60 * 25;              // 60 transfers of up to 25 cycles
   int          aw_cnt = 0, ar_cnt = 0, r_cnt = 0;
   logic        r_busy = 1'b0;
   logic [31:0] r_addr;
   logic [31:0] bad_rd_addr = bridge_pkg::dccm_base + 32'h0000_0100;

   ahb_to_axi_bridge i_ahb_to_axi_bridge (.*);

   always #20 ahb_clk = ~ahb_clk;                  // 40 ns period

   function automatic logic [63:0] rdata_of(input logic [31:0] addr);
      return {addr ^ 32'h5a5a_0f0f, ~addr};
   endfunction

   // Reference model of the decode rules and the expected AXI beat
   function automatic exp_t predict(input logic [31:0] addr, input logic [2:0] size,
                                    input logic write, input logic [63:0] wdata);
      exp_t        e;
      logic        in_win;
      logic [15:0] lanes;
      in_win    = (addr >= bridge_pkg::dccm_base) &&
                  ((addr - bridge_pkg::dccm_base) < bridge_pkg::dccm_size);
      lanes     = (16'd1 << (16'd1 << size)) - 16'd1;   // One bit per byte of the size
      e.dec_err = !in_win || (write && size < bridge_pkg::hsize_word) ||
                  ((addr % (32'd1 << size)) != 0);
      e.rd_err  = !write && (addr == bad_rd_addr);
      e.write   = write;
      e.addr    = addr;
      e.size    = size;
      e.data    = write ? wdata : rdata_of(addr);
      e.strb    = 8'(lanes << addr[2:0]);
      return e;
   endfunction

   task automatic check_field(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      checks++;
      assert (got === want)
      else begin
         errors++;
         $display("FAIL %0t %s expected %h got %h", $time, name, want, got);
      end
   endtask

   // AHB master running the address phase then the data phase without overlap
   task automatic ahb_xfer(input logic [31:0] addr, input logic [2:0] size,
                           input logic write);
      exp_t        e;
      logic [63:0] wdata;
      wdata = {$urandom, $urandom};
      e     = predict(addr, size, write, wdata);
      if (!e.dec_err && write) begin
         aw_exp_q.push_back(e);
      end
      if (!e.dec_err && !write) begin
         ar_exp_q.push_back(e);
      end
      haddr  <= addr;
      hsize  <= size;
      hwrite <= write;
      htrans <= bridge_pkg::htrans_nonseq;
      @(posedge ahb_clk);
      while (!hreadyout) begin
         @(posedge ahb_clk);
      end
      htrans  <= bridge_pkg::htrans_idle;          // Accepted on this edge
      hwdata  <= wdata;
      dphase  <= 1'b1;
      cur_exp <= e;
      @(posedge ahb_clk);
      while (!hreadyout) begin
         @(posedge ahb_clk);
      end
      dphase <= 1'b0;
   endtask

   // Let owed beats drain, then report the test
   task automatic finish_test(input string name);
      while (aw_exp_q.size() != 0 || ar_exp_q.size() != 0 || awvalid || arvalid) begin
         @(posedge ahb_clk);
      end
      $display("%s: %0d errors", name, errors - err_mark);
      err_mark = errors;
   endtask

   //***********************************************************************
   // AXI slave model where wready always tracks awready
   //***********************************************************************
   always @(posedge ahb_clk) begin
      if (rst) begin
         awready <= 1'b0;
         wready  <= 1'b0;
      end else if (awvalid && awready) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         aw_cnt  = $urandom_range(5, 0);
      end else if (awvalid) begin
         if (aw_cnt == 0) begin
            awready <= 1'b1;
            wready  <= 1'b1;
         end else begin
            aw_cnt = aw_cnt - 1;
         end
      end
   end

   always @(posedge ahb_clk) begin
      if (rst) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         r_busy  = 1'b0;
      end else begin
         if (rvalid) begin
            rvalid <= 1'b0;                        // rready is always high
         end else if (r_busy) begin
            if (r_cnt == 0) begin
               rvalid <= 1'b1;
               r.data <= rdata_of(r_addr);
               r.resp <= (r_addr == bad_rd_addr) ? 2'b10 : bridge_pkg::axi_resp_okay;
               r_busy = 1'b0;
            end else begin
               r_cnt = r_cnt - 1;
            end
         end
         if (arvalid && arready) begin
            arready <= 1'b0;
            ar_cnt  = $urandom_range(5, 0);
            r_addr  = ar.addr;
            r_cnt   = $urandom_range(5, 0);
            r_busy  = 1'b1;
         end else if (arvalid) begin
            if (ar_cnt == 0) begin
               arready <= 1'b1;
            end else begin
               ar_cnt = ar_cnt - 1;
            end
         end
      end
   end

   //***********************************************************************
   // Compare process
   //***********************************************************************
   always @(posedge ahb_clk) begin
      if (!rst) begin
         if (awvalid && awready) begin
            assert (aw_exp_q.size() != 0)
            else begin
               errors++;
               $display("%0t: AW beat issued with no write outstanding", $time);
            end
            if (aw_exp_q.size() != 0) begin
               aw_e = aw_exp_q.pop_front();
               check_field("aw.addr", aw.addr, aw_e.addr);
               check_field("aw.size", aw.size, aw_e.size);
               check_field("wvalid", wvalid, 1'b1);
               check_field("w.data", w.data, aw_e.data);
               check_field("w.strb", w.strb, aw_e.strb);
            end
         end
         if (arvalid && arready) begin
            assert (ar_exp_q.size() != 0)
            else begin
               errors++;
               $display("%0t: AR beat issued with no read outstanding", $time);
            end
            if (ar_exp_q.size() != 0) begin
               ar_e = ar_exp_q.pop_front();
               check_field("ar.addr", ar.addr, ar_e.addr);
               check_field("ar.size", ar.size, ar_e.size);
            end
         end
         if (dphase && hreadyout) begin            // Data phase ends here
            check_field("hresp", hresp, cur_exp.dec_err | cur_exp.rd_err);
            if (!cur_exp.write && !cur_exp.dec_err && !cur_exp.rd_err) begin
               check_field("hrdata", hrdata, cur_exp.data);
            end
         end
      end
   end

   // Run limit
   always @(posedge ahb_clk) begin
      cycles++;
      if (cycles >= max_cycles) begin
         $display("Timeout after %0d cycles with transfers still open", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   //***********************************************************************
   // Stimulus
   //***********************************************************************
   initial begin
      logic [2:0]  sz;
      logic        wr;
      logic [31:0] ad;
      void'($urandom(32'h017a4c5d));
      rst      <= 1'b1;
      haddr    <= '0;
      hsize    <= '0;
      htrans   <= bridge_pkg::htrans_idle;
      hwrite   <= 1'b0;
      hwdata   <= '0;
      hsel     <= 1'b1;
      hreadyin <= 1'b1;
      dphase   <= 1'b0;
      repeat (3) @(posedge ahb_clk);
      check_field("hreadyout", hreadyout, 1'b1);   // Reset values
      check_field("hresp", hresp, 1'b0);
      check_field("awvalid", awvalid, 1'b0);
      check_field("arvalid", arvalid, 1'b0);
      rst <= 1'b0;

      ahb_xfer(bridge_pkg::dccm_base + 32'h10, bridge_pkg::hsize_word, 1'b1);
      ahb_xfer(bridge_pkg::dccm_base + 32'h18, bridge_pkg::hsize_dword, 1'b1);
      ahb_xfer(bridge_pkg::dccm_base + 32'h24, bridge_pkg::hsize_word, 1'b1);   // Upper lanes
      ahb_xfer(bridge_pkg::dccm_base + 32'hfff8, bridge_pkg::hsize_dword, 1'b1);
      finish_test("aligned writes");

      ahb_xfer(bridge_pkg::dccm_base + 32'h21, bridge_pkg::hsize_byte, 1'b0);
      ahb_xfer(bridge_pkg::dccm_base + 32'h32, bridge_pkg::hsize_half, 1'b0);
      ahb_xfer(bridge_pkg::dccm_base + 32'h44, bridge_pkg::hsize_word, 1'b0);
      ahb_xfer(bridge_pkg::dccm_base + 32'h58, bridge_pkg::hsize_dword, 1'b0);
      finish_test("aligned reads");

      ahb_xfer(32'hf003_fff8, bridge_pkg::hsize_dword, 1'b0);   // Below the window
      ahb_xfer(32'hf005_0000, bridge_pkg::hsize_word, 1'b1);    // Above the window
      ahb_xfer(bridge_pkg::dccm_base + 32'h41, bridge_pkg::hsize_half, 1'b0);
      ahb_xfer(bridge_pkg::dccm_base + 32'h42, bridge_pkg::hsize_word, 1'b0);
      ahb_xfer(bridge_pkg::dccm_base + 32'h14, bridge_pkg::hsize_dword, 1'b1);
      ahb_xfer(bridge_pkg::dccm_base + 32'h30, bridge_pkg::hsize_byte, 1'b1);
      ahb_xfer(bridge_pkg::dccm_base + 32'h30, bridge_pkg::hsize_half, 1'b1);
      finish_test("rejected requests");

      ahb_xfer(bad_rd_addr, bridge_pkg::hsize_word, 1'b0);
      ahb_xfer(bridge_pkg::dccm_base + 32'h108, bridge_pkg::hsize_dword, 1'b0);  // Recovery
      finish_test("read response error");

      for (int i = 0; i < 40; i++) begin
         wr = 1'($urandom_range(1, 0));
         sz = wr ? 3'(2 + $urandom_range(1, 0)) : 3'($urandom_range(3, 0));
         ad = bridge_pkg::dccm_base + ($urandom_range(32'hffff, 0) & ~((32'd1 << sz) - 1));
         ahb_xfer(ad, sz, wr);
      end
      finish_test("random traffic");

      chk_fails = i_ahb_to_axi_bridge.i_bridge_chk.fail_cnt;
      $display("Summary: %0d checks, %0d errors, %0d protocol assertion failures",
               checks, errors, chk_fails);
      if (errors == 0 && chk_fails == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: verilog/ahb_to_axi_bridge.sv
//**************************************************************************
// AHB-Lite slave to AXI4 master bridge for the DCCM window
// Downstream must accept read data and write responses at all times
// wready is expected to follow awready
//**************************************************************************
`timescale 1ns/1ps

module ahb_to_axi_bridge (
   input  logic                               ahb_clk,
   input  logic                               rst,

   // AHB-Lite slave
   input  logic [bridge_pkg::addr_w-1:0]      haddr,
   input  logic [2:0]                         hsize,
   input  logic [1:0]                         htrans,
   input  logic                               hwrite,
   input  logic [bridge_pkg::data_w-1:0]      hwdata,
   input  logic                               hsel,
   input  logic                               hreadyin,
   output logic                               hreadyout,
   output logic                               hresp,
   output logic [bridge_pkg::data_w-1:0]      hrdata,

   // AXI4 master
   output logic                               awvalid,
   input  logic                               awready,
   output bridge_pkg::axi_addr_t              aw,
   output logic                               wvalid,
   input  logic                               wready,   // Covered by awready
   output bridge_pkg::axi_w_t                 w,
   output logic                               arvalid,
   input  logic                               arready,
   output bridge_pkg::axi_addr_t              ar,
   input  logic                               rvalid,
   input  bridge_pkg::axi_r_t                 r
);

   bridge_pkg::ahb_req_t              req;         // Registered address phase
   logic                              req_err;
   logic [bridge_pkg::strb_w-1:0]     wstrb;
   logic                              cmd_load;
   logic                              cmd_full;

   ahb_slave_ctrl i_ahb_slave_ctrl (
      .ahb_clk   (ahb_clk),
      .rst       (rst),
      .haddr     (haddr),
      .hsize     (hsize),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hsel      (hsel),
      .hreadyin  (hreadyin),
      .hreadyout (hreadyout),
      .hresp     (hresp),
      .hrdata    (hrdata),
      .req       (req),
      .req_err   (req_err),
      .cmd_load  (cmd_load),
      .cmd_full  (cmd_full),
      .rvalid    (rvalid),
      .r         (r)
   );

   ahb_req_decode i_ahb_req_decode (
      .req     (req),
      .req_err (req_err),
      .wstrb   (wstrb)
   );

   axi_cmd_buf i_axi_cmd_buf (
      .ahb_clk  (ahb_clk),
      .rst      (rst),
      .cmd_load (cmd_load),
      .req      (req),
      .wstrb    (wstrb),
      .hwdata   (hwdata),
      .cmd_full (cmd_full),
      .awvalid  (awvalid),
      .awready  (awready),
      .aw       (aw),
      .wvalid   (wvalid),
      .w        (w),
      .arvalid  (arvalid),
      .arready  (arready),
      .ar       (ar)
   );

endmodule
